// ==== rtl/can_pkg.sv ====
`default_nettype none

package can_pkg;

	// ==============================
	// Frame geometry
	// ==============================

	localparam int CNT_W = 7;                        // Bit counter width, up to 64 data bits

	localparam logic [CNT_W-1:0] LEN_ID_A     = 7'd11;   // Base identifier
	localparam logic [CNT_W-1:0] LEN_ID_B     = 7'd18;   // Identifier extension
	localparam logic [CNT_W-1:0] LEN_DLC      = 7'd4;
	localparam logic [CNT_W-1:0] LEN_CRC      = 7'd15;
	localparam logic [CNT_W-1:0] LEN_EOF      = 7'd7;    // All recessive
	localparam logic [CNT_W-1:0] LEN_BUS_IDLE = 7'd11;   // Recessive run ending error recovery

	localparam logic [3:0]  MAX_DLC  = 4'd8;         // DLC codes 9..15 mean 8 bytes
	localparam logic [14:0] CRC_POLY = 15'h4599;     // x15+x14+x10+x8+x7+x4+x3+1

	// ==============================
	// Receiver states
	// ==============================

	typedef enum logic [3:0] {
		st_idle,          // Bus idle, waiting for SOF
		st_id_a,
		st_srr_rtr,       // RTR in base frame, SRR in extended frame
		st_ide,
		st_id_b,
		st_rtr,           // Extended frame only
		st_res1,          // Extended frame only
		st_res0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delim,
		st_ack_slot,
		st_ack_delim,
		st_eof,
		st_error_wait     // Waiting for bus idle after an error
	} can_state_t;

	typedef enum logic [2:0] {
		err_none,
		err_stuff,        // Six equal bits in stuffed region
		err_crc,          // Received CRC differs from computed one
		err_form,         // Fixed-form bit has wrong level
		err_ack           // Nobody acknowledged
	} can_err_t;

	// Bit stuffing covers everything from the identifier up to the CRC field
	function automatic logic stuff_state(input can_state_t s);
		return s inside {st_id_a, st_srr_rtr, st_ide, st_id_b, st_rtr,
			st_res1, st_res0, st_dlc, st_data, st_crc};
	endfunction

endpackage

`default_nettype wire

// ==== rtl/can_destuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_destuffer (
	input  logic                clock,
	input  logic                reset,
	input  logic                rx_bit,
	input  logic                sample_point,
	input  can_pkg::can_state_t state,
	output logic                stuff_bit,
	output logic                stuff_error
);
	import can_pkg::*;

	logic [4:0] history;    // Last five bus bits, newest in bit 0
	logic       region;     // Stuffing rule applies to this sample
	logic       run_low;    // Five dominant bits in a row
	logic       run_high;   // Five recessive bits in a row

	// A stuff bit may still follow the last CRC bit, seen while in crc_delim
	assign region   = stuff_state(state) || (state == st_crc_delim);
	assign run_low  = (history == 5'b00000);
	assign run_high = (history == 5'b11111);

	// Opposite level after a run is the inserted bit
	assign stuff_bit   = sample_point && region && ((run_low && rx_bit) || (run_high && !rx_bit));
	// Same level again is a sixth equal bit
	assign stuff_error = sample_point && region && ((run_low && !rx_bit) || (run_high && rx_bit));

	// History includes stuff bits, as they start the next run
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= 5'b11111;                // Idle bus is recessive
		else if (sample_point)
			history <= {history[3:0], rx_bit};
	end

	// Inserted bit and stuff violation exclude each other
	assert property (@(posedge clock) disable iff (reset) !(stuff_bit && stuff_error));

endmodule

`default_nettype wire

// ==== rtl/can_crc15.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_crc15 (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          rx_bit,
	input  logic                          sample_point,
	input  logic                          stuff_bit,
	input  logic                          crc_clear,
	input  can_pkg::can_state_t           state,
	output logic [can_pkg::LEN_CRC-1:0]   crc_calc
);
	import can_pkg::*;

	logic shift_en;
	logic feedback;

	// Covered bits end with the last data bit, the CRC field is excluded
	assign shift_en = sample_point && !stuff_bit && stuff_state(state) && (state != st_crc);
	assign feedback = rx_bit ^ crc_calc[14];

	// SOF is dominant and shifts a zero into a cleared register, so clearing in idle covers it
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_calc <= '0;
		else if (crc_clear)
			crc_calc <= '0;
		else if (shift_en)
			crc_calc <= {crc_calc[13:0], 1'b0} ^ (feedback ? CRC_POLY : 15'h0000);
	end

endmodule

`default_nettype wire

// ==== rtl/can_bit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_bit_counter (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        sample_point,
	input  logic                        stuff_bit,
	input  logic                        count_clear,
	output logic [can_pkg::CNT_W-1:0]   bit_count
);
	import can_pkg::*;

	logic take;    // Real bit, not inserted by the transmitter

	assign take = sample_point && !stuff_bit;

	// ==============================
	// Destuffed bits in current field
	// ==============================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			bit_count <= '0;
		else if (count_clear)
			bit_count <= '0;                    // State change or restart of a wait
		else if (take && (bit_count != '1))
			bit_count <= bit_count + 1'b1;      // Saturates at all ones
	end

	// FSM leaves every field before the count passes the largest data field
	assert property (@(posedge clock) disable iff (reset)
		bit_count <= {MAX_DLC, 3'b000});

endmodule

`default_nettype wire

// ==== rtl/can_rx_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_rx_fsm (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          rx_bit,
	input  logic                          sample_point,
	input  logic                          stuff_bit,
	input  logic                          stuff_error,
	input  logic [can_pkg::CNT_W-1:0]     bit_count,
	input  logic [can_pkg::LEN_DLC-1:0]   dlc,
	input  logic                          ide,
	input  logic                          rtr,
	input  logic [can_pkg::LEN_CRC-1:0]   crc_rx,
	input  logic [can_pkg::LEN_CRC-1:0]   crc_calc,
	output can_pkg::can_state_t           state,
	output logic                          crc_clear,
	output logic                          count_clear,
	output logic                          frame_valid,
	output logic                          frame_error,
	output can_pkg::can_err_t             error_code
);
	import can_pkg::*;

	can_state_t       state_next;
	can_err_t         err_next;
	logic             valid_next;
	logic             take;          // Destuffed sample
	logic             sof;
	logic [3:0]       dlc_next;      // DLC including the bit now on the bus
	logic [CNT_W-1:0] data_bits;     // Data field length in bits

	assign take      = sample_point && !stuff_bit;
	assign sof       = (state == st_idle) && sample_point && !rx_bit;
	assign dlc_next  = {dlc[2:0], rx_bit};
	assign data_bits = {dlc, 3'b000};   // DLC already clamped to 8

	assign crc_clear   = (state == st_idle);
	// Dominant bit restarts the bus idle wait
	assign count_clear = sample_point && ((state_next != state) || (state == st_idle) ||
		((state == st_error_wait) && !rx_bit));

	// ==============================
	// Next state and checks
	// ==============================

	always_comb
	begin
		state_next = state;
		err_next   = err_none;
		valid_next = 1'b0;
		case (state)
			st_idle:
				if (sof)
					state_next = st_id_a;
			st_id_a:
				if (take && (bit_count == LEN_ID_A - 1'b1))
					state_next = st_srr_rtr;
			st_srr_rtr:
				if (take)
					state_next = st_ide;
			st_ide:
				if (take)
				begin
					if (!rx_bit)
						state_next = st_res0;     // Base frame
					else if (!rtr)
						err_next = err_form;      // rtr still holds the SRR bit, must be recessive
					else
						state_next = st_id_b;
				end
			st_id_b:
				if (take && (bit_count == LEN_ID_B - 1'b1))
					state_next = st_rtr;
			st_rtr:
				if (take)
					state_next = st_res1;
			st_res1:
				if (take)
					state_next = st_res0;
			st_res0:
				if (take)
					state_next = st_dlc;
			st_dlc:
				if (take && (bit_count == LEN_DLC - 1'b1))
					state_next = ((dlc_next == 4'd0) || rtr) ? st_crc : st_data;  // No payload
			st_data:
				if (take && (bit_count == data_bits - 1'b1))
					state_next = st_crc;
			st_crc:
				if (take && (bit_count == LEN_CRC - 1'b1))
					state_next = st_crc_delim;
			st_crc_delim:
				if (take)
				begin
					if (!rx_bit)
						err_next = err_form;
					else
						state_next = st_ack_slot;
				end
			st_ack_slot:
				if (sample_point)
				begin
					if (rx_bit)
						err_next = err_ack;       // No receiver drove ACK
					else
						state_next = st_ack_delim;
				end
			st_ack_delim:
				if (sample_point)
				begin
					if (crc_calc != crc_rx)
						err_next = err_crc;       // CRC reported here, after the ACK slot
					else if (!rx_bit)
						err_next = err_form;
					else
						state_next = st_eof;
				end
			st_eof:
				if (sample_point)
				begin
					if (!rx_bit)
						err_next = err_form;
					else if (bit_count == LEN_EOF - 1'b1)
					begin
						state_next = st_idle;
						valid_next = 1'b1;
					end
				end
			st_error_wait:
				if (sample_point && rx_bit && (bit_count == LEN_BUS_IDLE - 1'b1))
					state_next = st_idle;
			default:
				state_next = st_idle;
		endcase

		// Stuff violation wins over anything else in the same bit
		if (stuff_error)
			err_next = err_stuff;
		if (err_next != err_none)
			state_next = st_error_wait;
	end

	// ==============================
	// State and result registers
	// ==============================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_code  <= err_none;
		end
		else
		begin
			state       <= state_next;
			frame_valid <= valid_next;                  // One cycle on last EOF bit
			frame_error <= (err_next != err_none);      // One cycle on offending bit
			if (err_next != err_none)
				error_code <= err_next;
			else if (sof)
				error_code <= err_none;                 // Held until next SOF
		end
	end

	// All 16 codes are states, so a known value is a legal one
	assert property (@(posedge clock) disable iff (reset) !$isunknown(state));

	// Extended-only states need IDE captured as recessive
	assert property (@(posedge clock) disable iff (reset)
		(state inside {st_id_b, st_rtr, st_res1}) |-> ide);

endmodule

`default_nettype wire

// ==== rtl/can_field_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_field_capture (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          rx_bit,
	input  logic                          sample_point,
	input  logic                          stuff_bit,
	input  can_pkg::can_state_t           state,
	output logic [can_pkg::LEN_ID_A-1:0]  id_a,
	output logic                          ide,
	output logic                          srr,
	output logic                          rtr,
	output logic [can_pkg::LEN_ID_B-1:0]  id_b,
	output logic [can_pkg::LEN_DLC-1:0]   dlc,
	output logic [63:0]                   data,
	output logic [can_pkg::LEN_CRC-1:0]   crc_rx
);
	import can_pkg::*;

	logic       take;
	logic [3:0] dlc_shift;    // DLC with current bit shifted in

	assign take      = sample_point && !stuff_bit;
	assign dlc_shift = {dlc[2:0], rx_bit};

	// ==============================
	// Field shift registers
	// ==============================

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			id_a   <= '0;
			ide    <= 1'b0;
			srr    <= 1'b0;
			rtr    <= 1'b0;
			id_b   <= '0;
			dlc    <= '0;
			data   <= '0;
			crc_rx <= '0;
		end
		else if (take)
		begin
			case (state)
				st_idle:
					if (!rx_bit)                          // SOF
					begin
						id_b <= '0;                       // Stays zero in a base frame
						data <= '0;                       // Stays zero for remote or short frames
						dlc  <= '0;                       // Lets the clamp see only the final shift
					end
				st_id_a:
					id_a <= {id_a[LEN_ID_A-2:0], rx_bit};
				st_srr_rtr:
				begin
					srr <= rx_bit;                        // Meaningful in extended frame only
					rtr <= rx_bit;                        // Final in base frame
				end
				st_ide:
					ide <= rx_bit;
				st_id_b:
					id_b <= {id_b[LEN_ID_B-2:0], rx_bit};
				st_rtr:
					rtr <= rx_bit;                        // Extended frame RTR
				st_dlc:
					dlc <= (dlc_shift > MAX_DLC) ? MAX_DLC : dlc_shift;
				st_data:
					data <= {data[62:0], rx_bit};         // First byte ends up highest
				st_crc:
					crc_rx <= {crc_rx[LEN_CRC-2:0], rx_bit};
				default:
					;                                     // Delimiters, reserved, ACK, EOF
			endcase
		end
	end

	// Clamp holds because dlc starts from zero at every SOF
	assert property (@(posedge clock) disable iff (reset) dlc <= MAX_DLC);

endmodule

`default_nettype wire

// ==== rtl/can_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module can_decoder (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          rx_bit,         // 1 is recessive
	input  logic                          sample_point,   // One-cycle strobe per bus bit
	output logic                          frame_valid,
	output logic                          frame_error,
	output can_pkg::can_err_t             error_code,
	output logic [can_pkg::LEN_ID_A-1:0]  id_a,
	output logic                          ide,
	output logic                          srr,
	output logic                          rtr,
	output logic [can_pkg::LEN_ID_B-1:0]  id_b,
	output logic [can_pkg::LEN_DLC-1:0]   dlc,
	output logic [63:0]                   data,
	output logic [can_pkg::LEN_CRC-1:0]   crc_rx
);
	import can_pkg::*;

	can_state_t         state;
	logic               stuff_bit;
	logic               stuff_error;
	logic               crc_clear;
	logic               count_clear;
	logic [CNT_W-1:0]   bit_count;
	logic [LEN_CRC-1:0] crc_calc;

	// ==============================
	// Control
	// ==============================

	can_rx_fsm u_fsm (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.stuff_error  (stuff_error),
		.bit_count    (bit_count),
		.dlc          (dlc),
		.ide          (ide),
		.rtr          (rtr),
		.crc_rx       (crc_rx),
		.crc_calc     (crc_calc),
		.state        (state),
		.crc_clear    (crc_clear),
		.count_clear  (count_clear),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_code   (error_code)
	);

	can_destuffer u_destuffer (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.state        (state),
		.stuff_bit    (stuff_bit),
		.stuff_error  (stuff_error)
	);

	can_bit_counter u_counter (
		.clock        (clock),
		.reset        (reset),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.count_clear  (count_clear),
		.bit_count    (bit_count)
	);

	// ==============================
	// Datapath
	// ==============================

	can_crc15 u_crc (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.crc_clear    (crc_clear),
		.state        (state),
		.crc_calc     (crc_calc)
	);

	can_field_capture u_fields (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.stuff_bit    (stuff_bit),
		.state        (state),
		.id_a         (id_a),
		.ide          (ide),
		.srr          (srr),
		.rtr          (rtr),
		.id_b         (id_b),
		.dlc          (dlc),
		.data         (data),
		.crc_rx       (crc_rx)
	);

endmodule

`default_nettype wire

// ==== include/can_tb_frames.svh ====
`ifndef CAN_TB_FRAMES_SVH
`define CAN_TB_FRAMES_SVH

// Frame helpers, included in the testbench top next to clock, rx_bit and sample_point

// One CRC-15 step over a single destuffed bit
function automatic logic [14:0] crc15_step(input logic [14:0] crc, input logic b);
	logic fb;
	fb = b ^ crc[14];
	return {crc[13:0], 1'b0} ^ (fb ? can_pkg::CRC_POLY : 15'h0000);
endfunction

// One bus bit over four clocks, strobe sampled on the second edge
task automatic drive_bit(input logic b);
	@(posedge clock);
	#1;
	rx_bit       = b;
	sample_point = 1'b1;
	@(posedge clock);
	#1;
	sample_point = 1'b0;
	repeat (2) @(posedge clock);
endtask

// body holds SOF up to the last data bit; crc_flip below zero leaves the CRC intact
task automatic send_frame(input logic body [$], input int crc_flip,
	input logic delim_bit, input logic ack_bit);
	logic [14:0] crc;
	logic        seq [$];
	logic        run_bit;
	int          run_len;
	crc = 15'h0000;
	foreach (body[i])
		crc = crc15_step(crc, body[i]);
	if (crc_flip >= 0)
		crc[crc_flip] = ~crc[crc_flip];
	seq = body;
	for (int i = 14; i >= 0; i--)
		seq.push_back(crc[i]);
	run_bit = 1'b1;                             // Bus idle before SOF
	run_len = 0;
	foreach (seq[i])
	begin
		drive_bit(seq[i]);
		if (seq[i] == run_bit)
			run_len++;
		else
		begin
			run_bit = seq[i];
			run_len = 1;
		end
		if (run_len == 5)
		begin
			drive_bit(~run_bit);                // Stuff bit opens the next run
			run_bit = ~run_bit;
			run_len = 1;
		end
	end
	drive_bit(delim_bit);                       // CRC delimiter
	drive_bit(ack_bit);                         // ACK slot, dominant when acknowledged
	drive_bit(1'b1);                            // ACK delimiter
	repeat (can_pkg::LEN_BUS_IDLE) drive_bit(1'b1);   // EOF, then enough idle to recover
endtask

`endif

// ==== tests/tb_can_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_can_decoder;
	import can_pkg::*;

	localparam int CLOCK_PERIOD   = 10;
	localparam int RESET_CYCLES   = 10;
	localparam int SEED           = 32'h7801_c703;
	localparam int NUM_TESTS      = 6;
	localparam int MAX_FRAME_BITS = 160;   // Longest stuffed frame plus idle
	localparam int CLOCKS_PER_BIT = 4;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_FRAME_BITS * CLOCKS_PER_BIT * 2;
	localparam int RESULT_WAIT    = 20 * CLOCKS_PER_BIT;

	logic                clock;
	logic                reset;
	logic                rx_bit;
	logic                sample_point;
	logic                frame_valid;
	logic                frame_error;
	can_err_t            error_code;
	logic [LEN_ID_A-1:0] id_a;
	logic                ide;
	logic                srr;
	logic                rtr;
	logic [LEN_ID_B-1:0] id_b;
	logic [LEN_DLC-1:0]  dlc;
	logic [63:0]         data;
	logic [LEN_CRC-1:0]  crc_rx;

	int   seed;
	int   error_count  = 0;
	int   check_count  = 0;
	int   test_count   = 0;
	int   cycle_count  = 0;
	int   valid_count  = 0;    // frame_valid pulses seen so far
	int   error_pulses = 0;    // frame_error pulses seen so far
	logic frame_body [$];      // SOF up to last data bit, unstuffed

	`include "can_tb_frames.svh"

	can_decoder UUT (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_code   (error_code),
		.id_a         (id_a),
		.ide          (ide),
		.srr          (srr),
		.rtr          (rtr),
		.id_b         (id_b),
		.dlc          (dlc),
		.data         (data),
		.crc_rx       (crc_rx)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// Pulses counted mid-cycle, away from the active edge
	always @(negedge clock)
	begin
		if (frame_valid)
			valid_count++;
		if (frame_error)
			error_pulses++;
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, frames never finished", cycle_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ==============================
	// Compare tasks
	// ==============================

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_vec(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_err(input string name, input can_err_t expected, input can_err_t actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Waits for a result pulse, then checks how many of each arrived
	task automatic await_result(input int valid_before, input int error_before,
		input int valid_exp, input int error_exp);
		int waited;
		waited = 0;
		while ((valid_count == valid_before) && (error_pulses == error_before) &&
			(waited < RESULT_WAIT))
		begin
			@(negedge clock);
			waited++;
		end
		check_count++;
		if (valid_count - valid_before != valid_exp)
		begin
			$display("Expected %0d frame_valid pulse(s) but saw %0d", valid_exp,
				valid_count - valid_before);
			error_count++;
		end
		if (error_pulses - error_before != error_exp)
		begin
			$display("Expected %0d frame_error pulse(s) but saw %0d", error_exp,
				error_pulses - error_before);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("Test %0d, %s: ok", test_count, name);
		else
			$display("Test %0d, %s: %0d error(s)", test_count, name, error_count - errors_before);
	endtask

	// ==============================
	// Frame building
	// ==============================

	// Remote frames carry no data, codes above 8 mean 8 bytes
	function automatic int payload_bytes(input logic rtr_bit, input logic [3:0] dlc_code);
		if (rtr_bit)
			return 0;
		if (dlc_code > 4'd8)
			return 8;
		return int'(dlc_code);
	endfunction

	function automatic logic [14:0] body_crc();
		logic [14:0] crc;
		crc = 15'h0000;
		foreach (frame_body[i])
			crc = crc15_step(crc, frame_body[i]);
		return crc;
	endfunction

	task automatic append_bits(input logic [63:0] value, input int width);
		for (int i = width - 1; i >= 0; i--)
			frame_body.push_back(value[i]);     // MSB first on the bus
	endtask

	task automatic build_frame(input logic ext, input logic [10:0] ida, input logic [17:0] idb,
		input logic rtr_bit, input logic [3:0] dlc_code, input logic [63:0] payload);
		frame_body.delete();
		frame_body.push_back(1'b0);             // SOF
		append_bits(64'(ida), int'(LEN_ID_A));
		if (ext)
		begin
			frame_body.push_back(1'b1);         // SRR
			frame_body.push_back(1'b1);         // IDE
			append_bits(64'(idb), int'(LEN_ID_B));
			frame_body.push_back(rtr_bit);
			frame_body.push_back(1'b0);         // r1
		end
		else
		begin
			frame_body.push_back(rtr_bit);
			frame_body.push_back(1'b0);         // IDE
		end
		frame_body.push_back(1'b0);             // r0
		append_bits(64'(dlc_code), int'(LEN_DLC));
		append_bits(payload, 8 * payload_bytes(rtr_bit, dlc_code));
	endtask

	// Fields after a good frame, data keeps only the bytes sent
	task automatic verify_fields(input logic ext, input logic [10:0] ida, input logic [17:0] idb,
		input logic rtr_bit, input logic [3:0] dlc_code, input logic [63:0] payload);
		int          nbytes;
		logic [63:0] mask;
		logic [3:0]  exp_dlc;
		nbytes  = payload_bytes(rtr_bit, dlc_code);
		mask    = (nbytes == 8) ? '1 : ((64'h1 << (8 * nbytes)) - 64'h1);
		exp_dlc = (dlc_code > MAX_DLC) ? MAX_DLC : dlc_code;
		check_vec("id_a", 64'(ida), 64'(id_a));
		check_bit("ide", ext, ide);
		if (ext)
			check_bit("srr", 1'b1, srr);
		check_bit("rtr", rtr_bit, rtr);
		check_vec("id_b", ext ? 64'(idb) : 64'h0, 64'(id_b));
		check_vec("dlc", 64'(exp_dlc), 64'(dlc));
		check_vec("data", payload & mask, data);
		check_vec("crc_rx", 64'(body_crc()), 64'(crc_rx));
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic base_data_frame();
		logic [63:0] payload;
		int          e0;
		int          v0;
		int          f0;
		e0      = error_count;
		v0      = valid_count;
		f0      = error_pulses;
		payload = {$random(seed), $random(seed)};
		build_frame(1'b0, 11'h5A3, 18'h0, 1'b0, 4'd8, payload);
		send_frame(frame_body, -1, 1'b1, 1'b0);
		await_result(v0, f0, 1, 0);
		verify_fields(1'b0, 11'h5A3, 18'h0, 1'b0, 4'd8, payload);
		report_test("base data frame, DLC 8", e0);
	endtask

	task automatic extended_data_frame();
		logic [63:0] payload;
		int          e0;
		int          v0;
		int          f0;
		e0      = error_count;
		v0      = valid_count;
		f0      = error_pulses;
		payload = {$random(seed), $random(seed)};
		build_frame(1'b1, 11'h7F0, 18'h3C01F, 1'b0, 4'd3, payload);   // Long runs force stuffing
		send_frame(frame_body, -1, 1'b1, 1'b0);
		await_result(v0, f0, 1, 0);
		verify_fields(1'b1, 11'h7F0, 18'h3C01F, 1'b0, 4'd3, payload);
		report_test("extended data frame, DLC 3", e0);
	endtask

	task automatic remote_frame();
		int e0;
		int v0;
		int f0;
		e0 = error_count;
		v0 = valid_count;
		f0 = error_pulses;
		build_frame(1'b0, 11'h2C4, 18'h0, 1'b1, 4'd5, 64'h0);
		send_frame(frame_body, -1, 1'b1, 1'b0);
		await_result(v0, f0, 1, 0);
		verify_fields(1'b0, 11'h2C4, 18'h0, 1'b1, 4'd5, 64'h0);   // Data must stay zero
		report_test("remote frame, DLC 5", e0);
	endtask

	task automatic stuff_violation();
		int e0;
		int v0;
		int f0;
		e0 = error_count;
		v0 = valid_count;
		f0 = error_pulses;
		drive_bit(1'b0);                        // SOF
		repeat (5) drive_bit(1'b0);             // Sixth dominant bit in a row
		repeat (LEN_BUS_IDLE + 1) drive_bit(1'b1);
		await_result(v0, f0, 0, 1);
		check_err("error_code", err_stuff, error_code);
		report_test("stuff error in identifier", e0);
	endtask

	task automatic crc_and_ack_errors();
		logic [63:0] payload;
		int          e0;
		int          v0;
		int          f0;
		e0      = error_count;
		v0      = valid_count;
		f0      = error_pulses;
		payload = {$random(seed), $random(seed)};
		build_frame(1'b0, 11'h123, 18'h0, 1'b0, 4'd2, payload);
		send_frame(frame_body, 3, 1'b1, 1'b0);  // CRC bit 3 inverted
		await_result(v0, f0, 0, 1);
		check_err("error_code", err_crc, error_code);
		v0 = valid_count;
		f0 = error_pulses;
		send_frame(frame_body, -1, 1'b1, 1'b1); // Nobody acknowledges
		await_result(v0, f0, 0, 1);
		check_err("error_code", err_ack, error_code);
		report_test("CRC and ACK errors", e0);
	endtask

	task automatic form_error_recovery();
		logic [63:0] payload;
		int          e0;
		int          v0;
		int          f0;
		e0      = error_count;
		v0      = valid_count;
		f0      = error_pulses;
		payload = {$random(seed), $random(seed)};
		build_frame(1'b1, 11'h0F5, 18'h1ABCD, 1'b0, 4'd4, payload);
		send_frame(frame_body, -1, 1'b0, 1'b0); // Dominant CRC delimiter
		await_result(v0, f0, 0, 1);
		check_err("error_code", err_form, error_code);
		// Trailing idle of the bad frame lets the decoder recover
		v0      = valid_count;
		f0      = error_pulses;
		payload = {$random(seed), $random(seed)};
		build_frame(1'b0, 11'h3E7, 18'h0, 1'b0, 4'd6, payload);
		send_frame(frame_body, -1, 1'b1, 1'b0);
		await_result(v0, f0, 1, 0);
		verify_fields(1'b0, 11'h3E7, 18'h0, 1'b0, 4'd6, payload);
		check_err("error_code", err_none, error_code);   // Cleared at SOF
		report_test("form error and recovery", e0);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		rx_bit       = 1'b1;                    // Recessive idle bus
		sample_point = 1'b0;
		reset        = 1'b1;
		seed         = SEED;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		repeat (4) @(posedge clock);

		base_data_frame();
		extended_data_frame();
		remote_frame();
		stuff_violation();
		crc_and_ack_errors();
		form_error_recovery();

		$display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
rtl/can_pkg.sv
rtl/can_destuffer.sv
rtl/can_crc15.sv
rtl/can_bit_counter.sv
rtl/can_rx_fsm.sv
rtl/can_field_capture.sv
rtl/can_decoder.sv
tests/tb_can_decoder.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_can_decoder
LOG       ?= sim.log
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
